// ==== la32_decode.f ====
+incdir+hw
+incdir+dv
hw/la32_decode_pkg.sv
hw/op_decoder.sv
hw/imm_gen.sv
hw/uop_queue.sv
hw/decode_stage.sv
dv/decode_stage_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds and runs the decode stage testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/100ps -f la32_decode.f \
    --top-module decode_stage_tb -Mdir obj_dir -o decode_sim \
    && ./obj_dir/decode_sim | tee /dev/stderr | grep -q "^all tests passed$" \
    && echo "PASS" \
    || { echo "FAIL"; exit 1; }

// ==== dv/decode_vectors.svh ====
`ifndef DECODE_VECTORS_SVH
`define DECODE_VECTORS_SVH

// Columns: group, ir, pc, exec_unit, sub_op, alu_op, src1_sel, src2_sel,
//          rj, rk, rd, imm, {reg_write, mem_read, mem_write, redirect}, excp_code (0 = none)
task automatic load_vectors();
    // Reg-reg ALU, rd 3 rj 4 rk 5
    add_row(1, 32'h00101483, 32'h1c000000, UNIT_ALU, 0, ALU_ADD, SRC1_REG, SRC2_REG,
            4, 5, 3, 32'h00000000, 4'b1000, 0);
    add_row(1, 32'h00111483, 32'h1c000004, UNIT_ALU, 0, ALU_SUB, SRC1_REG, SRC2_REG,
            4, 5, 3, 32'h00000000, 4'b1000, 0);
    add_row(1, 32'h00129483, 32'h1c000008, UNIT_ALU, 0, ALU_SLTU, SRC1_REG, SRC2_REG,
            4, 5, 3, 32'h00000000, 4'b1000, 0);
    add_row(1, 32'h00141483, 32'h1c00000c, UNIT_ALU, 0, ALU_NOR, SRC1_REG, SRC2_REG,
            4, 5, 3, 32'h00000000, 4'b1000, 0);
    add_row(1, 32'h00159483, 32'h1c000010, UNIT_ALU, 0, ALU_XOR, SRC1_REG, SRC2_REG,
            4, 5, 3, 32'h00000000, 4'b1000, 0);
    add_row(1, 32'h00181483, 32'h1c000014, UNIT_ALU, 0, ALU_SRA, SRC1_REG, SRC2_REG,
            4, 5, 3, 32'h00000000, 4'b1000, 0);
    // Immediate forms
    add_row(2, 32'h02bffc83, 32'h1c000018, UNIT_ALU, 0, ALU_ADD, SRC1_REG, SRC2_IMM,
            4, 0, 3, 32'hffffffff, 4'b1000, 0);     // ADDI.W -1
    add_row(2, 32'h02200083, 32'h1c00001c, UNIT_ALU, 0, ALU_SLT, SRC1_REG, SRC2_IMM,
            4, 0, 3, 32'hfffff800, 4'b1000, 0);     // SLTI -2048
    add_row(2, 32'h037ffc83, 32'h1c000020, UNIT_ALU, 0, ALU_AND, SRC1_REG, SRC2_IMM,
            4, 0, 3, 32'h00000fff, 4'b1000, 0);     // ANDI zero-extends
    add_row(2, 32'h03a00083, 32'h1c000024, UNIT_ALU, 0, ALU_OR, SRC1_REG, SRC2_IMM,
            4, 0, 3, 32'h00000800, 4'b1000, 0);
    add_row(2, 32'h0040fc83, 32'h1c000028, UNIT_ALU, 0, ALU_SLL, SRC1_REG, SRC2_IMM,
            4, 0, 3, 32'h0000001f, 4'b1000, 0);     // SLLI.W 31
    add_row(2, 32'h0048fc83, 32'h1c00002c, UNIT_ALU, 0, ALU_SRA, SRC1_REG, SRC2_IMM,
            4, 0, 3, 32'h0000001f, 4'b1000, 0);
    add_row(2, 32'h15000023, 32'h1c000030, UNIT_ALU, 0, ALU_PASS_B, SRC1_REG, SRC2_IMM,
            0, 0, 3, 32'h80001000, 4'b1000, 0);     // LU12I.W
    add_row(2, 32'h1c000203, 32'h1c000034, UNIT_ALU, 0, ALU_ADD, SRC1_PC, SRC2_IMM,
            0, 0, 3, 32'h00010000, 4'b1000, 0);     // PCADDU12I
    // Branches and jumps
    add_row(3, 32'h53fff3ff, 32'h1c000038, UNIT_BRANCH, 0, ALU_AND, SRC1_REG, SRC2_REG,
            0, 0, 0, 32'hfffffff0, 4'b0001, 0);     // B back 4 words
    add_row(3, 32'h54002000, 32'h1c00003c, UNIT_LINK, 1, ALU_ADD, SRC1_PC, SRC2_FOUR,
            0, 0, 1, 32'h00000020, 4'b1001, 0);     // BL
    add_row(3, 32'h4c001021, 32'h1c000040, UNIT_LINK, 0, ALU_ADD, SRC1_PC, SRC2_FOUR,
            1, 0, 1, 32'h00000010, 4'b1001, 0);     // JIRL
    add_row(3, 32'h5bfffc83, 32'h1c000044, UNIT_BRANCH, 1, ALU_SUB, SRC1_REG, SRC2_RD,
            4, 0, 3, 32'hfffffffc, 4'b0001, 0);     // BEQ
    add_row(3, 32'h64004083, 32'h1c000048, UNIT_BRANCH, 4, ALU_SLT, SRC1_REG, SRC2_RD,
            4, 0, 3, 32'h00000040, 4'b0001, 0);     // BGE
    add_row(3, 32'h68000883, 32'h1c00004c, UNIT_BRANCH, 5, ALU_SLTU, SRC1_REG, SRC2_RD,
            4, 0, 3, 32'h00000008, 4'b0001, 0);     // BLTU
    // Memory, multiply, divide
    add_row(4, 32'h28bff083, 32'h1c000050, UNIT_MEM, 2, ALU_AND, SRC1_REG, SRC2_REG,
            4, 0, 3, 32'hfffffffc, 4'b1100, 0);     // LD.W
    add_row(4, 32'h29002083, 32'h1c000054, UNIT_MEM, 3, ALU_AND, SRC1_REG, SRC2_REG,
            4, 0, 3, 32'h00000008, 4'b0010, 0);     // ST.B
    add_row(4, 32'h2a400083, 32'h1c000058, UNIT_MEM, 7, ALU_AND, SRC1_REG, SRC2_REG,
            4, 0, 3, 32'h00000000, 4'b1100, 0);     // LD.HU
    add_row(4, 32'h001c1483, 32'h1c00005c, UNIT_MUL, 0, ALU_AND, SRC1_REG, SRC2_REG,
            4, 5, 3, 32'h00000000, 4'b1000, 0);
    add_row(4, 32'h001d1483, 32'h1c000060, UNIT_MUL, 2, ALU_AND, SRC1_REG, SRC2_REG,
            4, 5, 3, 32'h00000000, 4'b1000, 0);
    add_row(4, 32'h00201483, 32'h1c000064, UNIT_DIV, 0, ALU_AND, SRC1_REG, SRC2_REG,
            4, 5, 3, 32'h00000000, 4'b1000, 0);
    add_row(4, 32'h00219483, 32'h1c000068, UNIT_DIV, 3, ALU_AND, SRC1_REG, SRC2_REG,
            4, 5, 3, 32'h00000000, 4'b1000, 0);
    // Exceptions and nops
    add_row(5, 32'h00101483, 32'h1c000002, UNIT_EXCP, 0, ALU_AND, SRC1_REG, SRC2_REG,
            0, 0, 0, 32'h00000000, 4'b0000, `LA_EXC_ADE);
    add_row(5, 32'h00000000, 32'h80000000, UNIT_EXCP, 0, ALU_AND, SRC1_REG, SRC2_REG,
            0, 0, 0, 32'h00000000, 4'b0000, `LA_EXC_ADE);
    add_row(5, 32'h002b0000, 32'h1c00006c, UNIT_EXCP, 0, ALU_AND, SRC1_REG, SRC2_REG,
            0, 0, 0, 32'h00000000, 4'b0000, `LA_EXC_SYS);
    add_row(5, 32'h002a0005, 32'h1c000070, UNIT_EXCP, 0, ALU_AND, SRC1_REG, SRC2_REG,
            0, 0, 0, 32'h00000000, 4'b0000, `LA_EXC_BRK);
    add_row(5, 32'h06483800, 32'h1c000074, UNIT_EXCP, 0, ALU_AND, SRC1_REG, SRC2_REG,
            0, 0, 0, 32'h00000000, 4'b0000, `LA_EXC_INE);     // ERTN
    add_row(5, 32'h38728000, 32'h1c000078, UNIT_EXCP, 0, ALU_AND, SRC1_REG, SRC2_REG,
            0, 0, 0, 32'h00000000, 4'b0000, `LA_EXC_INE);     // IBAR
    add_row(5, 32'hffffffff, 32'h1c00007c, UNIT_EXCP, 0, ALU_AND, SRC1_REG, SRC2_REG,
            0, 0, 0, 32'h00000000, 4'b0000, `LA_EXC_INE);
    add_row(5, 32'h00000000, 32'h1c000080, UNIT_NONE, 0, ALU_AND, SRC1_REG, SRC2_REG,
            0, 0, 0, 32'h00000000, 4'b0000, 0);
    add_row(5, 32'h2ac00000, 32'h1c000084, UNIT_NONE, 0, ALU_AND, SRC1_REG, SRC2_REG,
            0, 0, 0, 32'h00000000, 4'b0000, 0);     // PRELD
    add_row(5, 32'h38720000, 32'h1c000088, UNIT_NONE, 0, ALU_AND, SRC1_REG, SRC2_REG,
            0, 0, 0, 32'h00000000, 4'b0000, 0);     // DBAR
endtask

`endif

// ==== dv/decode_stage_tb.sv ====
`include "la32_decode_settings.svh"

module decode_stage_tb
    import la32_decode_pkg::*;
;
    timeunit 1ns;
    timeprecision 100ps;

    logic         clk = 1'b0;
    logic         reset;
    logic         in_valid;
    word_t        in_pc;
    word_t        in_ir;
    logic         out_credit;
    logic         in_credit;
    logic         out_valid;
    decoded_uop_t out_uop;

    decoded_uop_t rows_uop[$];
    word_t        rows_ir[$];
    int           rows_grp[$];
    string        grp_names [1:6];
    int           grp_rows [1:6];
    int           grp_errs [1:6];

    int nrows;
    int limit;
    int cycles = 0;
    int errors = 0;
    int flow_errs = 0;
    int check_idx = 0;
    int delivered = 0;
    int accepted = 0;       // Words taken from fetch
    int credit_pulses = 0;
    int fetch_credits = `LA_UOPQ_DEPTH;
    int granted = 0;        // out_credit pulses sent
    int spent = 0;          // Micro-ops taken by issue

    decode_stage dut (
        .clk        (clk),
        .reset      (reset),
        .in_valid   (in_valid),
        .in_pc      (in_pc),
        .in_ir      (in_ir),
        .out_credit (out_credit),
        .in_credit  (in_credit),
        .out_valid  (out_valid),
        .out_uop    (out_uop)
    );

    always #20 clk = ~clk;

    task automatic add_row(input int grp, input word_t ir, input word_t pc,
                           input exec_unit_e unit, input sub_op_t sub, input alu_op_e alu,
                           input src1_sel_e s1, input src2_sel_e s2,
                           input reg_idx_t rj, input reg_idx_t rk, input reg_idx_t rd,
                           input word_t imm, input logic [3:0] flags, input excp_code_t code);
        decoded_uop_t u;
        u = '{pc: pc, exec_unit: unit, sub_op: sub, alu_op: alu, src1_sel: s1,
              src2_sel: s2, rj: rj, rk: rk, rd: rd, imm: imm,
              reg_write: flags[3], mem_read: flags[2], mem_write: flags[1],
              redirect: flags[0], excp_valid: (code != '0), excp_code: code};
        rows_uop.push_back(u);
        rows_ir.push_back(ir);
        rows_grp.push_back(grp);
        grp_rows[grp]++;
    endtask

    `include "decode_vectors.svh"

    task automatic check_field(input string name, input logic [31:0] got,
                               input logic [31:0] exp, input int k);
        if (got !== exp)
        begin
            $display("Mismatch at %0t: row %0d ir %h field %s got %h expected %h",
                     $time, k, rows_ir[k], name, got, exp);
            errors++;
            grp_errs[rows_grp[k]]++;
        end
    endtask

    task automatic compare_uop(input int k);
        decoded_uop_t e;
        e = rows_uop[k];
        check_field("pc", out_uop.pc, e.pc, k);
        check_field("exec_unit", 32'(out_uop.exec_unit), 32'(e.exec_unit), k);
        check_field("sub_op", 32'(out_uop.sub_op), 32'(e.sub_op), k);
        check_field("alu_op", 32'(out_uop.alu_op), 32'(e.alu_op), k);
        check_field("src1_sel", 32'(out_uop.src1_sel), 32'(e.src1_sel), k);
        check_field("src2_sel", 32'(out_uop.src2_sel), 32'(e.src2_sel), k);
        check_field("rj", 32'(out_uop.rj), 32'(e.rj), k);
        check_field("rk", 32'(out_uop.rk), 32'(e.rk), k);
        check_field("rd", 32'(out_uop.rd), 32'(e.rd), k);
        check_field("imm", out_uop.imm, e.imm, k);
        check_field("reg_write", 32'(out_uop.reg_write), 32'(e.reg_write), k);
        check_field("mem_read", 32'(out_uop.mem_read), 32'(e.mem_read), k);
        check_field("mem_write", 32'(out_uop.mem_write), 32'(e.mem_write), k);
        check_field("redirect", 32'(out_uop.redirect), 32'(e.redirect), k);
        check_field("excp_valid", 32'(out_uop.excp_valid), 32'(e.excp_valid), k);
        check_field("excp_code", 32'(out_uop.excp_code), 32'(e.excp_code), k);
        if (k == nrows - 1 || rows_grp[k + 1] != rows_grp[k])
            $display("Group %0d %s: %0d rows, %0d errors", rows_grp[k],
                     grp_names[rows_grp[k]], grp_rows[rows_grp[k]], grp_errs[rows_grp[k]]);
    endtask

    // Scoreboard and credit bookkeeping, sampled on the rising edge
    always @(posedge clk)
    begin
        if (!reset)
        begin
            if (out_valid)
            begin
                if (granted - spent <= 0)
                begin
                    $display("Error at %0t: out_valid high without an unspent issue credit",
                             $time);
                    errors++;
                    flow_errs++;
                end
                if (check_idx >= nrows)
                begin
                    $display("Error at %0t: extra micro-op delivered after the last row", $time);
                    errors++;
                    flow_errs++;
                end
                else
                    compare_uop(check_idx);
                check_idx++;
                delivered++;
                spent++;
            end
            if (in_credit)
            begin
                credit_pulses++;
                fetch_credits++;
            end
            if (in_valid)
            begin
                accepted++;
                fetch_credits--;
            end
            if (fetch_credits > `LA_UOPQ_DEPTH)
            begin
                $display("Error at %0t: fetch credit count %0d above the queue depth", $time,
                         fetch_credits);
                errors++;
                flow_errs++;
            end
            if (accepted - delivered > `LA_UOPQ_DEPTH)
            begin
                $display("Error at %0t: %0d words outstanding in a %0d entry queue", $time,
                         accepted - delivered, `LA_UOPQ_DEPTH);
                errors++;
                flow_errs++;
            end
            if (out_credit)
                granted++;
        end
    end

    // Run limit
    always @(posedge clk)
    begin
        if (!reset)
            cycles++;
        if (cycles > limit)
        begin
            $display("Timeout after %0d cycles with %0d of %0d micro-ops delivered",
                     cycles, delivered, nrows);
            $display("tests failed");
            $finish;
        end
    end

    // Fetch model, sends only while holding a credit
    initial
    begin
        int idx;
        idx = 0;
        @(negedge reset);
        while (idx < nrows)
        begin
            @(posedge clk);
            #2;
            if (fetch_credits > 0)
            begin
                in_valid = 1'b1;
                in_pc    = rows_uop[idx].pc;
                in_ir    = rows_ir[idx];
                idx++;
            end
            else
                in_valid = 1'b0;
        end
        @(posedge clk);
        #2 in_valid = 1'b0;
    end

    // Random issue credits
    initial
    begin
        void'($urandom(32'hd5c3));
        @(negedge reset);
        forever
        begin
            @(posedge clk);
            #2 out_credit = ($urandom % 3) == 0;
        end
    end

    initial
    begin
        reset      = 1'b1;
        in_valid   = 1'b0;
        in_pc      = '0;
        in_ir      = '0;
        out_credit = 1'b0;
        grp_names  = '{"reg-reg ALU", "immediate", "branch", "memory and muldiv",
                       "exception and nop", "flow control"};
        load_vectors();
        nrows = rows_uop.size();
        limit = 40 * nrows + 100;
        repeat (2) @(posedge clk);
        #2 reset = 1'b0;
        wait (delivered == nrows);
        repeat (20) @(posedge clk);     // Catch stray micro-ops
        if (credit_pulses != delivered)
        begin
            $display("Error: %0d in_credit pulses for %0d micro-ops delivered",
                     credit_pulses, delivered);
            errors++;
            flow_errs++;
        end
        $display("Group 6 %s: %0d micro-ops, %0d errors", grp_names[6], delivered, flow_errs);
        $display("Rows %0d, delivered %0d, errors %0d", nrows, delivered, errors);
        if (errors == 0 && delivered == nrows)
            $display("all tests passed");
        else
            $display("tests failed");
        $finish;
    end

endmodule

// ==== hw/decode_stage.sv ====
module decode_stage
    import la32_decode_pkg::*;
(
    input  logic         clk,
    input  logic         reset,
    input  logic         in_valid,
    input  word_t        in_pc,
    input  word_t        in_ir,
    input  logic         out_credit,
    output logic         in_credit,
    output logic         out_valid,
    output decoded_uop_t out_uop
);

    exec_unit_e   exec_unit;
    sub_op_t      sub_op;
    alu_op_e      alu_op;
    src1_sel_e    src1_sel;
    src2_sel_e    src2_sel;
    reg_idx_t     rj;
    reg_idx_t     rk;
    reg_idx_t     rd;
    imm_fmt_e     imm_fmt;
    word_t        imm;
    logic         reg_write;
    logic         mem_read;
    logic         mem_write;
    logic         redirect;
    logic         excp_valid;
    excp_code_t   excp_code;
    decoded_uop_t push_uop;

    op_decoder u_op_decoder (
        .ir         (in_ir),
        .pc         (in_pc),
        .exec_unit  (exec_unit),
        .sub_op     (sub_op),
        .alu_op     (alu_op),
        .src1_sel   (src1_sel),
        .src2_sel   (src2_sel),
        .rj         (rj),
        .rk         (rk),
        .rd         (rd),
        .imm_fmt    (imm_fmt),
        .reg_write  (reg_write),
        .mem_read   (mem_read),
        .mem_write  (mem_write),
        .redirect   (redirect),
        .excp_valid (excp_valid),
        .excp_code  (excp_code)
    );

    imm_gen u_imm_gen (
        .ir      (in_ir),
        .imm_fmt (imm_fmt),
        .imm     (imm)
    );

    assign push_uop = '{
        pc:         in_pc,
        exec_unit:  exec_unit,
        sub_op:     sub_op,
        alu_op:     alu_op,
        src1_sel:   src1_sel,
        src2_sel:   src2_sel,
        rj:         rj,
        rk:         rk,
        rd:         rd,
        imm:        imm,
        reg_write:  reg_write,
        mem_read:   mem_read,
        mem_write:  mem_write,
        redirect:   redirect,
        excp_valid: excp_valid,
        excp_code:  excp_code
    };

    uop_queue u_uop_queue (
        .clk        (clk),
        .reset      (reset),
        .push       (in_valid),     // Fetch only sends while holding a credit
        .push_uop   (push_uop),
        .out_credit (out_credit),
        .in_credit  (in_credit),
        .out_valid  (out_valid),
        .out_uop    (out_uop)
    );

endmodule

// ==== hw/uop_queue.sv ====
`include "la32_decode_settings.svh"

module uop_queue
    import la32_decode_pkg::*;
(
    input  logic         clk,
    input  logic         reset,
    input  logic         push,
    input  decoded_uop_t push_uop,
    input  logic         out_credit,
    output logic         in_credit,
    output logic         out_valid,
    output decoded_uop_t out_uop
);

    localparam int depth  = `LA_UOPQ_DEPTH;
    localparam int ptr_w  = $clog2(depth);
    localparam int cnt_w  = $clog2(depth + 1);
    localparam int cred_w = $clog2(depth) + 2;  // Issue may grant past our depth

    decoded_uop_t      entries [depth];
    logic [ptr_w-1:0]  wr_ptr;
    logic [ptr_w-1:0]  rd_ptr;
    logic [cnt_w-1:0]  count;
    logic [cred_w-1:0] credits;    // Unspent issue credits
    logic              pop;

    function automatic logic [ptr_w-1:0] ptr_inc(input logic [ptr_w-1:0] ptr);
        return (ptr == ptr_w'(depth - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign pop       = (count != '0) && (credits != '0);
    assign out_valid = pop;
    assign in_credit = pop;        // Freed slot goes straight back to fetch
    assign out_uop   = entries[rd_ptr];

    always_ff @(posedge clk)
    begin
        if (push)
            entries[wr_ptr] <= push_uop;
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count   <= '0;
            credits <= '0;
        end
        else
        begin
            if (push)
                wr_ptr <= ptr_inc(wr_ptr);
            if (pop)
                rd_ptr <= ptr_inc(rd_ptr);

            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase

            case ({out_credit, pop})
                2'b10:   credits <= credits + 1'b1;
                2'b01:   credits <= credits - 1'b1;
                default: credits <= credits;        // Grant and spend cancel
            endcase
        end
    end

endmodule

// ==== hw/imm_gen.sv ====
module imm_gen
    import la32_decode_pkg::*;
(
    input  word_t    ir,
    input  imm_fmt_e imm_fmt,
    output word_t    imm
);

    always_comb
    begin
        case (imm_fmt)
            IMM_UI5:
                imm = {27'd0, ir[14:10]};       // Shift amount
            IMM_SI12:
                imm = {{20{ir[21]}}, ir[21:10]};
            IMM_UI12:
                imm = {20'd0, ir[21:10]};
            IMM_SI14_S2:
                imm = {{16{ir[23]}}, ir[23:10], 2'b00};
            IMM_SI16_S2:
                imm = {{14{ir[25]}}, ir[25:10], 2'b00};     // JIRL and conditional branches
            IMM_SI26_S2:
                imm = {{4{ir[9]}}, ir[9:0], ir[25:10], 2'b00};  // High offset bits sit in 9:0
            IMM_UI20:
                imm = {ir[24:5], 12'd0};
            default:
                imm = '0;
        endcase
    end

endmodule

// ==== hw/op_decoder.sv ====
`include "la32_decode_settings.svh"

module op_decoder
    import la32_decode_pkg::*;
(
    input  word_t      ir,
    input  word_t      pc,
    output exec_unit_e exec_unit,
    output sub_op_t    sub_op,
    output alu_op_e    alu_op,
    output src1_sel_e  src1_sel,
    output src2_sel_e  src2_sel,
    output reg_idx_t   rj,
    output reg_idx_t   rk,
    output reg_idx_t   rd,
    output imm_fmt_e   imm_fmt,
    output logic       reg_write,
    output logic       mem_read,
    output logic       mem_write,
    output logic       redirect,
    output logic       excp_valid,
    output excp_code_t excp_code
);

    logic rr_op;        // rd = rj op rk
    logic ri_op;        // rd = rj op imm
    logic mem_op;
    logic link_op;      // JIRL and BL
    logic cond_br;
    logic ine;

    // BEQ through BGEU sit on consecutive major opcodes
    assign cond_br = (ir[31:26] >= 6'b010110) && (ir[31:26] <= 6'b011011);

    always_comb
    begin
        exec_unit  = UNIT_NONE;
        sub_op     = '0;
        alu_op     = ALU_AND;
        src1_sel   = SRC1_REG;
        src2_sel   = SRC2_REG;
        rj         = '0;
        rk         = '0;
        rd         = '0;
        imm_fmt    = IMM_NONE;
        reg_write  = 1'b0;
        mem_read   = 1'b0;
        mem_write  = 1'b0;
        redirect   = 1'b0;
        excp_valid = 1'b0;
        excp_code  = '0;
        rr_op      = 1'b0;
        ri_op      = 1'b0;
        mem_op     = 1'b0;
        link_op    = 1'b0;
        ine        = 1'b0;

        if (pc[1:0] != 2'b00 || pc[31])
        begin
            exec_unit  = UNIT_EXCP;     // ADEF and ADEM share one code
            excp_valid = 1'b1;
            excp_code  = `LA_EXC_ADE;
        end
        else
        begin
            case (ir[31:26])
                6'b000000:
                    if (ir[25:22] == 4'b0000)
                    begin
                        rr_op     = 1'b1;
                        exec_unit = UNIT_ALU;
                        casez (ir[21:15])
                            7'b0000000:
                            begin
                                rr_op     = 1'b0;
                                exec_unit = UNIT_NONE;
                                ine       = (ir[14:0] != 15'd0);    // Only the zero word is a nop
                            end
                            7'b0100000: alu_op = ALU_ADD;       // ADD.W
                            7'b0100010: alu_op = ALU_SUB;       // SUB.W
                            7'b0100100: alu_op = ALU_SLT;       // SLT
                            7'b0100101: alu_op = ALU_SLTU;      // SLTU
                            7'b0101000: alu_op = ALU_NOR;       // NOR
                            7'b0101001: alu_op = ALU_AND;       // AND
                            7'b0101010: alu_op = ALU_OR;        // OR
                            7'b0101011: alu_op = ALU_XOR;       // XOR
                            7'b0101110: alu_op = ALU_SLL;       // SLL.W
                            7'b0101111: alu_op = ALU_SRL;       // SRL.W
                            7'b0110000: alu_op = ALU_SRA;       // SRA.W
                            7'b0111000, 7'b0111001, 7'b0111010:
                            begin
                                exec_unit = UNIT_MUL;
                                sub_op    = {2'b00, ir[16:15]};
                            end
                            7'b10000??:
                            begin
                                exec_unit = UNIT_DIV;
                                sub_op    = {2'b00, ir[16:15]};
                            end
                            7'b1010100, 7'b1010110:
                            begin
                                rr_op      = 1'b0;
                                exec_unit  = UNIT_EXCP;
                                excp_valid = 1'b1;
                                excp_code  = ir[16] ? `LA_EXC_SYS : `LA_EXC_BRK;
                            end
                            default: ine = 1'b1;
                        endcase
                    end
                    else
                    begin
                        ri_op   = 1'b1;
                        imm_fmt = ir[24] ? IMM_UI12 : IMM_SI12;     // Logic ops zero-extend
                        case (ir[25:22])
                            4'b0001:
                            begin
                                imm_fmt = IMM_UI5;      // SLLI.W SRLI.W SRAI.W
                                ine     = (ir[21:20] != 2'b00) || (ir[17:15] != 3'b001)
                                          || (ir[19:18] == 2'b11);
                                alu_op  = ir[19] ? ALU_SRA : (ir[18] ? ALU_SRL : ALU_SLL);
                            end
                            4'b1000: alu_op = ALU_SLT;      // SLTI
                            4'b1001: alu_op = ALU_SLTU;     // SLTUI
                            4'b1010: alu_op = ALU_ADD;      // ADDI.W
                            4'b1101: alu_op = ALU_AND;      // ANDI
                            4'b1110: alu_op = ALU_OR;       // ORI
                            4'b1111: alu_op = ALU_XOR;      // XORI
                            default: ine = 1'b1;
                        endcase
                    end
                6'b000101, 6'b000111:
                    if (!ir[25])
                    begin
                        exec_unit = UNIT_ALU;   // LU12I.W or PCADDU12I
                        alu_op    = ir[27] ? ALU_ADD : ALU_PASS_B;
                        src1_sel  = ir[27] ? SRC1_PC : SRC1_REG;
                        src2_sel  = SRC2_IMM;
                        imm_fmt   = IMM_UI20;
                        rd        = ir[4:0];
                        reg_write = 1'b1;
                    end
                    else
                        ine = 1'b1;
                6'b001010:
                begin
                    mem_op = 1'b1;
                    case (ir[25:22])
                        4'b0000: sub_op = 4'd0;     // LD.B
                        4'b0001: sub_op = 4'd1;     // LD.H
                        4'b0010: sub_op = 4'd2;     // LD.W
                        4'b0100: sub_op = 4'd3;     // ST.B
                        4'b0101: sub_op = 4'd4;     // ST.H
                        4'b0110: sub_op = 4'd5;     // ST.W
                        4'b1000: sub_op = 4'd6;     // LD.BU
                        4'b1001: sub_op = 4'd7;     // LD.HU
                        4'b1011: mem_op = 1'b0;     // PRELD
                        default: ine = 1'b1;
                    endcase
                end
                6'b001110: ine = (ir[25:15] != 11'b00011100100);   // DBAR, IBAR is gone
                6'b010011:
                begin
                    link_op = 1'b1;     // JIRL
                    imm_fmt = IMM_SI16_S2;
                    rj      = ir[9:5];
                    rd      = ir[4:0];
                end
                6'b010100:
                begin
                    exec_unit = UNIT_BRANCH;    // B
                    imm_fmt   = IMM_SI26_S2;
                    redirect  = 1'b1;
                end
                6'b010101:
                begin
                    link_op = 1'b1;     // BL writes the return address to r1
                    sub_op  = 4'd1;
                    imm_fmt = IMM_SI26_S2;
                    rd      = 5'd1;
                end
                6'b010110, 6'b010111: alu_op = ALU_SUB;     // BEQ BNE
                6'b011000, 6'b011001: alu_op = ALU_SLT;     // BLT BGE
                6'b011010, 6'b011011: alu_op = ALU_SLTU;    // BLTU BGEU
                default: ine = 1'b1;
            endcase

            if (ine)
            begin
                exec_unit  = UNIT_EXCP;
                alu_op     = ALU_AND;
                imm_fmt    = IMM_NONE;
                excp_valid = 1'b1;
                excp_code  = `LA_EXC_INE;
            end
            else
            begin
                if (rr_op || ri_op || mem_op || cond_br)
                begin
                    rj = ir[9:5];
                    rd = ir[4:0];
                end
                if (rr_op)
                begin
                    rk        = ir[14:10];
                    reg_write = 1'b1;
                end
                if (ri_op)
                begin
                    exec_unit = UNIT_ALU;
                    src2_sel  = SRC2_IMM;
                    reg_write = 1'b1;
                end
                if (mem_op)
                begin
                    exec_unit = UNIT_MEM;
                    imm_fmt   = IMM_SI12;
                    mem_read  = !ir[24];    // Stores have bit 24 set
                    mem_write = ir[24];
                    reg_write = !ir[24];
                end
                if (cond_br)
                begin
                    exec_unit = UNIT_BRANCH;
                    sub_op    = ir[29:26] - 4'd5;
                    src2_sel  = SRC2_RD;
                    imm_fmt   = IMM_SI16_S2;
                    redirect  = 1'b1;
                end
                if (link_op)
                begin
                    exec_unit = UNIT_LINK;
                    alu_op    = ALU_ADD;
                    src1_sel  = SRC1_PC;
                    src2_sel  = SRC2_FOUR;
                    reg_write = 1'b1;
                    redirect  = 1'b1;
                end
            end
        end
    end

endmodule

// ==== hw/la32_decode_pkg.sv ====
`include "la32_decode_settings.svh"

package la32_decode_pkg;

    typedef logic [`LA_WORD_W-1:0] word_t;
    typedef logic [`LA_REG_W-1:0]  reg_idx_t;
    typedef logic [`LA_EXCP_W-1:0] excp_code_t;

    // Unit-specific variant
    //   div    0 div.w  1 mod.w  2 div.wu  3 mod.wu
    //   mul    0 mul.w  1 mulh.w  2 mulh.wu
    //   mem    0 ld.b  1 ld.h  2 ld.w  3 st.b  4 st.h  5 st.w  6 ld.bu  7 ld.hu
    //   branch 0 b  1 beq  2 bne  3 blt  4 bge  5 bltu  6 bgeu
    //   link   0 jirl  1 bl
    typedef logic [3:0] sub_op_t;

    typedef enum logic [3:0] {
        UNIT_ALU    = 4'd0,
        UNIT_BRANCH = 4'd1,
        UNIT_DIV    = 4'd2,
        UNIT_EXCP   = 4'd3,
        UNIT_MUL    = 4'd4,
        UNIT_MEM    = 4'd5,
        UNIT_LINK   = 4'd8,     // ALU writes pc + 4 while the branch unit redirects
        UNIT_NONE   = 4'd15
    } exec_unit_e;

    typedef enum logic [3:0] {
        ALU_AND    = 4'd0,
        ALU_OR     = 4'd1,
        ALU_NOR    = 4'd2,
        ALU_XOR    = 4'd3,
        ALU_ADD    = 4'd4,
        ALU_SUB    = 4'd5,
        ALU_SLL    = 4'd6,
        ALU_SRL    = 4'd7,
        ALU_SRA    = 4'd8,
        ALU_SLT    = 4'd9,
        ALU_SLTU   = 4'd10,
        ALU_PASS_B = 4'd12
    } alu_op_e;

    typedef enum logic {
        SRC1_REG = 1'b0,
        SRC1_PC  = 1'b1
    } src1_sel_e;

    typedef enum logic [1:0] {
        SRC2_REG  = 2'd0,
        SRC2_IMM  = 2'd1,
        SRC2_RD   = 2'd2,   // Branch compares rj against rd
        SRC2_FOUR = 2'd3
    } src2_sel_e;

    typedef enum logic [2:0] {
        IMM_NONE,
        IMM_UI5,
        IMM_SI12,
        IMM_UI12,
        IMM_SI14_S2,
        IMM_SI16_S2,
        IMM_SI26_S2,
        IMM_UI20
    } imm_fmt_e;

    typedef struct packed {
        word_t      pc;
        exec_unit_e exec_unit;
        sub_op_t    sub_op;
        alu_op_e    alu_op;
        src1_sel_e  src1_sel;
        src2_sel_e  src2_sel;
        reg_idx_t   rj;
        reg_idx_t   rk;
        reg_idx_t   rd;
        word_t      imm;
        logic       reg_write;
        logic       mem_read;
        logic       mem_write;
        logic       redirect;
        logic       excp_valid;
        excp_code_t excp_code;
    } decoded_uop_t;

endpackage

// ==== hw/la32_decode_settings.svh ====
`ifndef LA32_DECODE_SETTINGS_SVH
`define LA32_DECODE_SETTINGS_SVH

// Datapath widths
`define LA_WORD_W       32
`define LA_REG_W        5
`define LA_EXCP_W       6

// Micro-op queue entries, also the fetch credit count after reset
`define LA_UOPQ_DEPTH   4

// Exception codes, sized to LA_EXCP_W
`define LA_EXC_ADE      6'd8    // ADEF and ADEM
`define LA_EXC_SYS      6'd11   // SYSCALL
`define LA_EXC_BRK      6'd12   // BREAK
`define LA_EXC_INE      6'd13   // Instruction not exist

`endif
